// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 8;
    localparam int REG_ADDR_W = 3;
    localparam int PC_W       = 32;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;

    localparam pc_t PC_STEP = pc_t'(4); // one 32-bit word per instruction

    // kept encodings of the instruction set, gaps are the removed ops
    typedef enum logic [7:0] {
        OP_LOADI = 8'd0,
        OP_MOV   = 8'd1,
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        OP_AND   = 8'd4,
        OP_OR    = 8'd5,
        OP_J     = 8'd6,
        OP_BEQ   = 8'd7,
        OP_BNE   = 8'd12
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0, // operand b straight through
        ALU_ADD  = 2'd1,
        ALU_AND  = 2'd2,
        ALU_OR   = 2'd3
    } alu_op_e;

    // register numbers sit in the low bits of their byte
    typedef struct packed {
        opcode_e                        opcode;
        logic [DATA_W-REG_ADDR_W-1:0]   rd_pad;
        reg_addr_t                      rd;
        logic [DATA_W-REG_ADDR_W-1:0]   rs1_pad;
        reg_addr_t                      rs1;
        data_t                          imm;    // also rs2 byte
    } alu_fmt_t;

    typedef struct packed {
        opcode_e                        opcode;
        logic signed [DATA_W-1:0]       offset; // in words, from pc+4
        logic [DATA_W-REG_ADDR_W-1:0]   rs1_pad;
        reg_addr_t                      rs1;
        logic [DATA_W-REG_ADDR_W-1:0]   rs2_pad;
        reg_addr_t                      rs2;
    } flow_fmt_t;

    // byte 2 is a destination or an offset depending on the opcode
    typedef union packed {
        alu_fmt_t  alu;
        flow_fmt_t flow;
    } instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    negate_b;  // two's complement of source 2
        logic    use_imm;   // immediate as operand b
        logic    reg_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

endpackage

// File: src/control_decoder.sv
`timescale 1ns/1ps

module control_decoder import cpu_pkg::*;
(
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    always_comb
    begin
        ctrl = '0; // everything inactive unless the opcode says otherwise
        case (opcode)
            OP_LOADI:
            begin
                ctrl.alu_op    = ALU_PASS;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_MOV:
            begin
                ctrl.alu_op    = ALU_PASS; // passes source 2
                ctrl.reg_write = 1'b1;
            end
            OP_ADD:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
            end
            OP_SUB:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.negate_b  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_AND:
            begin
                ctrl.alu_op    = ALU_AND;
                ctrl.reg_write = 1'b1;
            end
            OP_OR:
            begin
                ctrl.alu_op    = ALU_OR;
                ctrl.reg_write = 1'b1;
            end
            OP_J:
                ctrl.jump = 1'b1;
            // branches compare by subtracting and looking at zero
            OP_BEQ:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.negate_b  = 1'b1;
                ctrl.branch_eq = 1'b1;
            end
            OP_BNE:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.negate_b  = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            default:
                ctrl = '0; // unknown opcode acts as a no-op
        endcase
    end

endmodule

// File: src/program_counter.sv
`timescale 1ns/1ps

module program_counter import cpu_pkg::*;
#(
    parameter pc_t RESET_PC = '0
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  ctrl_t                    ctrl,
    input  logic signed [DATA_W-1:0] offset,
    input  logic                     zero,
    output pc_t                      pc
);

    pc_t  pc_plus4;
    pc_t  offset_ext;   // sign extended byte offset
    pc_t  target;
    logic take_branch;
    pc_t  pc_next;

    assign pc_plus4 = pc + PC_STEP;

    // shift by two turns the word offset into a byte offset
    assign offset_ext = {{(PC_W-DATA_W-2){offset[DATA_W-1]}}, offset, 2'b00};

    // jump and branch share the same pc-relative target
    assign target = pc_plus4 + offset_ext;

    assign take_branch = (ctrl.branch_eq &  zero)
                       | (ctrl.branch_ne & ~zero);

    always_comb
    begin
        if (ctrl.jump || take_branch)
            pc_next = target;
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*;
#(
    parameter int NUM_REGS = 8 // at most 2**REG_ADDR_W
)
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data,
    input  reg_addr_t rd_addr_1,
    input  reg_addr_t rd_addr_2,
    output data_t     rd_data_1,
    output data_t     rd_data_2
);

    data_t regs [NUM_REGS];

    // write lands at the edge, readable by the next instruction
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_addr < NUM_REGS))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // unimplemented register numbers read as zero
    assign rd_data_1 = (rd_addr_1 < NUM_REGS) ? regs[rd_addr_1] : '0;
    assign rd_data_2 = (rd_addr_2 < NUM_REGS) ? regs[rd_addr_2] : '0;

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*;
(
    input  ctrl_t ctrl,
    input  data_t src_a,
    input  data_t src_b,
    input  data_t imm,
    output data_t result,
    output logic  zero
);

    data_t operand_b;

    // immediate wins over negate, decoder never sets both
    always_comb
    begin
        if (ctrl.use_imm)
            operand_b = imm;
        else if (ctrl.negate_b)
            operand_b = ~src_b + 1'b1;
        else
            operand_b = src_b;
    end

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_PASS:
                result = operand_b;         // loadi and mov
            ALU_ADD:
                result = src_a + operand_b; // wraps at 8 bits
            ALU_AND:
                result = src_a & operand_b;
            ALU_OR:
                result = src_a | operand_b;
            default:
                result = '0;
        endcase
    end

    // high when a subtraction found equal operands
    assign zero = (result == '0);

endmodule

// File: src/cpu.sv
`timescale 1ns/1ps

module cpu import cpu_pkg::*;
#(
    parameter pc_t RESET_PC = '0
)
(
    input  logic   CLK,
    input  logic   RESET,
    input  instr_t instr,   // held stable for the whole cycle
    output pc_t    pc
);

    ctrl_t ctrl;
    data_t rd_data_1;
    data_t rd_data_2;
    data_t alu_result;
    logic  zero;

    control_decoder u_control_decoder (
        .opcode (instr.alu.opcode),
        .ctrl   (ctrl)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) u_program_counter (
        .CLK    (CLK),
        .RESET  (RESET),
        .ctrl   (ctrl),
        .offset (instr.flow.offset), // byte 2 read as an offset
        .zero   (zero),
        .pc     (pc)
    );

    reg_file #(
        .NUM_REGS (1 << REG_ADDR_W)
    ) u_reg_file (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr_en     (ctrl.reg_write),
        .wr_addr   (instr.alu.rd),   // byte 2 read as a destination
        .wr_data   (alu_result),
        .rd_addr_1 (instr.alu.rs1),
        .rd_addr_2 (instr.flow.rs2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    alu u_alu (
        .ctrl   (ctrl),
        .src_a  (rd_data_1),
        .src_b  (rd_data_2),
        .imm    (instr.alu.imm),
        .result (alu_result),
        .zero   (zero)
    );

endmodule

// File: tb/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*;
#(
    parameter pc_t RESET_PC = '0
)
(
    input logic  CLK,
    input logic  RESET,
    input pc_t   pc,
    input ctrl_t ctrl
);

    int unsigned fail_count = 0; // assertion failures so far

    // instructions are whole words
    property pc_word_aligned;
        @(posedge CLK) disable iff (RESET)
            pc[1:0] == 2'b00;
    endproperty

    property pc_after_reset;
        @(posedge CLK) RESET |=> (pc == RESET_PC);
    endproperty

    property jump_not_with_branch;
        @(posedge CLK) disable iff (RESET)
            !(ctrl.jump && (ctrl.branch_eq || ctrl.branch_ne));
    endproperty

    assert property (pc_word_aligned)
    else
    begin
        fail_count++;
        $error("pc %h is not a multiple of 4", pc);
    end

    assert property (pc_after_reset)
    else
    begin
        fail_count++;
        $error("pc %h after reset, expected %h", pc, RESET_PC);
    end

    assert property (jump_not_with_branch)
    else
    begin
        fail_count++;
        $error("jump raised together with a branch control");
    end

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*;
();

    localparam pc_t         RESET_PC      = '0;
    localparam int unsigned SEED          = 30053;
    localparam int          RESET_TIMEOUT = 10;      // cycles
    localparam logic [7:0]  OP_UNKNOWN    = 8'hFF;   // not a kept opcode

    typedef struct {
        string  name;
        instr_t instr;
        logic   reset;
        pc_t    exp_pc;
    } step_t;

    logic   CLK = 1'b0;
    logic   RESET;
    instr_t instr;
    pc_t    pc;

    step_t steps[$];
    data_t model_regs [8];     // shadow register file
    pc_t   model_pc;
    int    checks = 0;
    int    errors = 0;

    cpu #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .instr (instr),
        .pc    (pc)
    );

    bind cpu cpu_asserts #(
        .RESET_PC (RESET_PC)
    ) u_asserts (
        .CLK   (CLK),
        .RESET (RESET),
        .pc    (pc),
        .ctrl  (ctrl)
    );

    always #20 CLK = ~CLK;

    function automatic instr_t encode_instr(logic [7:0] op, logic [7:0] b2,
                                            logic [7:0] b1, logic [7:0] b0);
        instr_t word;
        word = instr_t'({op, b2, b1, b0});
        return word;
    endfunction

    // reference model, one instruction per call, result goes into the table
    task automatic add_step(input string name, input instr_t ins);
        logic [31:0] raw;
        reg_addr_t   rd;
        data_t       a;
        data_t       b;
        data_t       imm;
        int          off_words;
        pc_t         seq;
        pc_t         target;
        step_t       s;
        raw       = ins;
        rd        = raw[18:16];
        a         = model_regs[raw[10:8]];
        b         = model_regs[raw[2:0]];
        imm       = raw[7:0];
        off_words = $signed(raw[23:16]);
        seq       = model_pc + 32'd4;
        target    = seq + pc_t'(off_words * 4);
        model_pc  = seq;
        case (raw[31:24])
            OP_LOADI: model_regs[rd] = imm;
            OP_MOV:   model_regs[rd] = b;
            OP_ADD:   model_regs[rd] = a + b;
            OP_SUB:   model_regs[rd] = a - b;
            OP_AND:   model_regs[rd] = a & b;
            OP_OR:    model_regs[rd] = a | b;
            OP_J:     model_pc = target;
            OP_BEQ:
                if (a == b)
                    model_pc = target;
            OP_BNE:
                if (a != b)
                    model_pc = target;
            default:  ; // no-op, just pc+4
        endcase
        s.name   = name;
        s.instr  = ins;
        s.reset  = 1'b0;
        s.exp_pc = model_pc;
        steps.push_back(s);
    endtask

    task automatic add_reset_step(input string name);
        step_t s;
        foreach (model_regs[i])
            model_regs[i] = '0;
        model_pc = RESET_PC;
        s.name   = name;
        s.instr  = encode_instr(OP_UNKNOWN, 8'h00, 8'h00, 8'h00);
        s.reset  = 1'b1;
        s.exp_pc = RESET_PC;
        steps.push_back(s);
    endtask

    task automatic build_table();
        data_t x;
        data_t y;
        foreach (model_regs[i])
            model_regs[i] = '0;
        model_pc = RESET_PC;
        x = data_t'($urandom);
        y = data_t'($urandom);
        add_step("seq_unknown", encode_instr(OP_UNKNOWN, 8'h00, 8'h00, 8'h00));
        add_step("seq_loadi_r0", encode_instr(OP_LOADI, 8'd0, 8'd0, 8'h5C));
        add_step("seq_unknown_0d", encode_instr(8'h0D, 8'h03, 8'h01, 8'h02));
        // equal registers through loadi and mov
        add_step("eq_loadi_r1", encode_instr(OP_LOADI, 8'd1, 8'd0, x));
        add_step("eq_mov_r2", encode_instr(OP_MOV, 8'd2, 8'd0, 8'd1));
        add_step("eq_beq_fwd", encode_instr(OP_BEQ, 8'd3, 8'd1, 8'd2));
        add_step("eq_beq_back", encode_instr(OP_BEQ, 8'hFE, 8'd1, 8'd2));
        add_step("eq_bne_fall", encode_instr(OP_BNE, 8'd5, 8'd1, 8'd2));
        add_step("eq_loadi_r3", encode_instr(OP_LOADI, 8'd3, 8'd0, y));
        add_step("eq_bne_r1_r3", encode_instr(OP_BNE, 8'd6, 8'd1, 8'd3));
        // add and sub against preloaded sums
        add_step("as_loadi_r3", encode_instr(OP_LOADI, 8'd3, 8'd0, x));
        add_step("as_loadi_r4", encode_instr(OP_LOADI, 8'd4, 8'd0, y));
        add_step("as_add_r5", encode_instr(OP_ADD, 8'd5, 8'd3, 8'd4));
        add_step("as_loadi_sum", encode_instr(OP_LOADI, 8'd6, 8'd0, data_t'(x + y)));
        add_step("as_beq_sum", encode_instr(OP_BEQ, 8'd4, 8'd5, 8'd6));
        add_step("as_sub_r7", encode_instr(OP_SUB, 8'd7, 8'd3, 8'd4));
        add_step("as_loadi_diff", encode_instr(OP_LOADI, 8'd6, 8'd0, data_t'(x - y)));
        add_step("as_bne_diff", encode_instr(OP_BNE, 8'd4, 8'd7, 8'd6));
        add_step("as_beq_r5_r7", encode_instr(OP_BEQ, 8'd2, 8'd5, 8'd7));
        add_step("wrap_loadi_r3", encode_instr(OP_LOADI, 8'd3, 8'd0, 8'hF0));
        add_step("wrap_loadi_r4", encode_instr(OP_LOADI, 8'd4, 8'd0, 8'h20));
        add_step("wrap_add_r5", encode_instr(OP_ADD, 8'd5, 8'd3, 8'd4));
        add_step("wrap_loadi_10", encode_instr(OP_LOADI, 8'd6, 8'd0, 8'h10));
        add_step("wrap_beq_sum", encode_instr(OP_BEQ, 8'd1, 8'd5, 8'd6));
        add_step("wrap_sub_r7", encode_instr(OP_SUB, 8'd7, 8'd4, 8'd3));
        add_step("wrap_loadi_30", encode_instr(OP_LOADI, 8'd6, 8'd0, 8'h30));
        add_step("wrap_beq_diff", encode_instr(OP_BEQ, 8'hFF, 8'd7, 8'd6));
        // and / or
        add_step("lg_loadi_r3", encode_instr(OP_LOADI, 8'd3, 8'd0, x));
        add_step("lg_loadi_r4", encode_instr(OP_LOADI, 8'd4, 8'd0, y));
        add_step("lg_and_r5", encode_instr(OP_AND, 8'd5, 8'd3, 8'd4));
        add_step("lg_loadi_and", encode_instr(OP_LOADI, 8'd6, 8'd0, x & y));
        add_step("lg_beq_and", encode_instr(OP_BEQ, 8'd3, 8'd5, 8'd6));
        add_step("lg_or_r5", encode_instr(OP_OR, 8'd5, 8'd3, 8'd4));
        add_step("lg_loadi_or", encode_instr(OP_LOADI, 8'd6, 8'd0, x | y));
        add_step("lg_bne_or", encode_instr(OP_BNE, 8'd3, 8'd5, 8'd6));
        add_step("lg_beq_r5_r3", encode_instr(OP_BEQ, 8'd2, 8'd5, 8'd3));
        // jumps ignore registers, then a reset clears them
        add_step("j_loadi_r1", encode_instr(OP_LOADI, 8'd1, 8'd0, 8'h11));
        add_step("j_loadi_r2", encode_instr(OP_LOADI, 8'd2, 8'd0, 8'h22));
        add_step("j_fwd", encode_instr(OP_J, 8'd7, 8'd1, 8'd2));
        add_step("j_back", encode_instr(OP_J, 8'hFD, 8'd1, 8'd2));
        add_reset_step("mid_run_reset");
        add_step("clr_beq_r1_r2", encode_instr(OP_BEQ, 8'd2, 8'd1, 8'd2));
        add_step("clr_bne_r3_r4", encode_instr(OP_BNE, 8'd2, 8'd3, 8'd4));
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s: expected pc %h, actual pc %h", name, expected, actual);
        end
    endtask

    // pc must settle to the reset address while reset is held
    task automatic wait_reset_done(output bit ok);
        int cycles;
        ok = 1'b0;
        for (cycles = 0; cycles < RESET_TIMEOUT; cycles++)
        begin
            if (pc === RESET_PC)
            begin
                ok = 1'b1;
                break;
            end
            @(posedge CLK);
            #1;
        end
    endtask

    // entered 1 ns after an edge, each step checked 1 ns after the next
    task automatic run_table();
        step_t s;
        foreach (steps[i])
        begin
            s     = steps[i];
            RESET = s.reset;
            instr = s.instr;
            @(posedge CLK);
            #1;
            check_pc(s.name, s.exp_pc, pc);
        end
        RESET = 1'b0;
        instr = encode_instr(OP_UNKNOWN, 8'h00, 8'h00, 8'h00);
    endtask

    initial
    begin
        bit reset_ok;
        int total_errors;
        RESET = 1'b1;
        instr = encode_instr(OP_UNKNOWN, 8'h00, 8'h00, 8'h00);
        void'($urandom(SEED));
        build_table();
        repeat (3) @(posedge CLK);
        #1;
        wait_reset_done(reset_ok);
        if (!reset_ok)
        begin
            $display("reset never completed, pc did not reach the reset address");
            $display("Some tests failed");
            $finish;
        end
        else
        begin
            run_table();
            total_errors = errors + u_dut.u_asserts.fail_count;
            $display("checks run: %0d, pc mismatches: %0d, assertion failures: %0d",
                     checks, errors, u_dut.u_asserts.fail_count);
            if (total_errors == 0)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

// File: cpu.f
src/cpu_pkg.sv
src/control_decoder.sv
src/program_counter.sv
src/reg_file.sv
src/alu.sv
src/cpu.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/control_decoder.sv
      - src/program_counter.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/cpu.sv
  - target: test
    files:
      - tb/cpu_asserts.sv
      - tb/cpu_tb.sv
